/* mips_core.f */
mips_pkg.sv
ctrl_if.sv
dmem_if.sv
alu_control.sv
alu.sv
reg_file.sv
control_unit.sv
data_cache.sv
datapath.sv
mips_core.sv
tb_mips_core.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_mips_core
FILELIST  ?= mips_core.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* tb_mips_core.sv */
`timescale 1ns/100ps

module tb_mips_core;
    localparam int MAX_ROWS    = 64;
    localparam int HALT_CYCLES = 5;

    logic               clk;
    logic               arst_n;
    mips_pkg::word_t    instr;
    mips_pkg::word_t    pc;
    logic               halted;
    logic               wb_en;
    mips_pkg::reg_idx_t wb_reg;
    mips_pkg::word_t    wb_data;

    // Program word and expected write-back, indexed by word address
    mips_pkg::word_t    prog     [MAX_ROWS];
    logic               exp_en   [MAX_ROWS];
    mips_pkg::reg_idx_t exp_reg  [MAX_ROWS];
    mips_pkg::word_t    exp_val  [MAX_ROWS];
    int                 exp_hold [MAX_ROWS];
    logic               seen     [MAX_ROWS];

    int              prog_len;
    int              num_expected;
    mips_pkg::word_t halt_pc;
    mips_pkg::word_t syscall_word;
    int              cycle;
    int              cycle_limit;
    int              hold;
    mips_pkg::word_t last_pc;
    logic            timed_out;
    int              errors;
    int              checks;
    int              wb_count;
    int              i;

    mips_core u_dut (
        .clk     (clk),
        .arst_n  (arst_n),
        .instr   (instr),
        .pc      (pc),
        .halted  (halted),
        .wb_en   (wb_en),
        .wb_reg  (wb_reg),
        .wb_data (wb_data)
    );

    always #10 clk = ~clk;

    // Instruction memory, driven on the falling edge
    always @(negedge clk) begin : fetch
        int fetch_idx;
        fetch_idx = int'(pc[31:2]);
        if (fetch_idx < prog_len) begin
            instr = prog[fetch_idx];
        end else begin
            instr = syscall_word;
        end
    end

    function automatic mips_pkg::word_t rtype(input int rs, input int rt, input int rd,
                                              input int sh, input mips_pkg::funct_t fn);
        return {mips_pkg::OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
    endfunction

    function automatic mips_pkg::word_t itype(input mips_pkg::opcode_t op, input int rs,
                                              input int rt, input int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic mips_pkg::word_t jtype(input mips_pkg::opcode_t op, input int target);
        return {op, 26'(target >> 2)};
    endfunction

    task automatic write_row(input mips_pkg::word_t word, input int rd,
                             input mips_pkg::word_t val, input int hold_cycles);
        prog[prog_len]     = word;
        exp_en[prog_len]   = 1'b1;
        exp_reg[prog_len]  = 5'(rd);
        exp_val[prog_len]  = val;
        exp_hold[prog_len] = hold_cycles;
        seen[prog_len]     = 1'b0;
        prog_len++;
        num_expected++;
    endtask

    // Stores, branches, jumps and words that must be skipped
    task automatic silent_row(input mips_pkg::word_t word);
        prog[prog_len]     = word;
        exp_en[prog_len]   = 1'b0;
        exp_reg[prog_len]  = '0;
        exp_val[prog_len]  = '0;
        exp_hold[prog_len] = 0;
        seen[prog_len]     = 1'b0;
        prog_len++;
    endtask

    task automatic build_program();
        mips_pkg::word_t poison;
        poison       = itype(mips_pkg::OP_ADDI, 0, 24, 'h0bad);
        syscall_word = rtype(0, 0, 0, 0, mips_pkg::FN_SYSCALL);
        prog_len     = 0;
        num_expected = 0;
        // Operands
        write_row(itype(mips_pkg::OP_ADDI, 0, 1, 7), 1, 32'h0000_0007, 1);
        write_row(itype(mips_pkg::OP_ADDI, 0, 2, 'hfffd), 2, 32'hffff_fffd, 1);
        write_row(itype(mips_pkg::OP_ADDIU, 0, 3, 'hfffd), 3, 32'h0000_fffd, 1);
        write_row(itype(mips_pkg::OP_LUI, 0, 4, 'h1234), 4, 32'h1234_0000, 1);
        write_row(itype(mips_pkg::OP_ORI, 4, 4, 'h5678), 4, 32'h1234_5678, 1);
        // R-type arithmetic and logic
        write_row(rtype(1, 2, 5, 0, mips_pkg::FN_ADD), 5, 32'h0000_0004, 1);
        write_row(rtype(1, 2, 6, 0, mips_pkg::FN_SUB), 6, 32'h0000_000a, 1);
        write_row(rtype(4, 3, 7, 0, mips_pkg::FN_AND), 7, 32'h0000_5678, 1);
        write_row(rtype(1, 4, 8, 0, mips_pkg::FN_OR), 8, 32'h1234_567f, 1);
        write_row(rtype(4, 3, 9, 0, mips_pkg::FN_XOR), 9, 32'h1234_a985, 1);
        write_row(rtype(1, 0, 10, 0, mips_pkg::FN_NOR), 10, 32'hffff_fff8, 1);
        write_row(rtype(2, 1, 11, 0, mips_pkg::FN_SLT), 11, 32'h0000_0001, 1);
        write_row(rtype(1, 2, 12, 0, mips_pkg::FN_SLT), 12, 32'h0000_0000, 1);
        write_row(rtype(5, 1, 13, 0, mips_pkg::FN_SLLV), 13, 32'h0000_0070, 1);
        write_row(rtype(5, 2, 14, 0, mips_pkg::FN_SRLV), 14, 32'h0fff_ffff, 1);
        write_row(rtype(1, 2, 15, 0, mips_pkg::FN_MULT), 15, 32'hffff_ffeb, 1);
        write_row(rtype(6, 2, 16, 0, mips_pkg::FN_DIV), 16, 32'hffff_fffd, 1);
        write_row(rtype(1, 0, 17, 0, mips_pkg::FN_DIV), 17, 32'hffff_ffff, 1);
        // Sign versus zero extension of immediates
        write_row(itype(mips_pkg::OP_SLTI, 1, 18, 'hffff), 18, 32'h0000_0000, 1);
        write_row(itype(mips_pkg::OP_ANDI, 2, 19, 'hffff), 19, 32'h0000_fffd, 1);
        write_row(itype(mips_pkg::OP_XORI, 1, 20, 'h8000), 20, 32'h0000_8007, 1);
        // Shifts by shamt on a negative value
        write_row(rtype(0, 2, 21, 4, mips_pkg::FN_SLL), 21, 32'hffff_ffd0, 1);
        write_row(rtype(0, 2, 22, 4, mips_pkg::FN_SRL), 22, 32'h0fff_ffff, 1);
        write_row(rtype(0, 2, 23, 1, mips_pkg::FN_SRA), 23, 32'hffff_fffe, 1);
        write_row(rtype(1, 5, 24, 0, mips_pkg::FN_ADDU), 24, 32'h0000_000b, 1);
        write_row(rtype(5, 1, 25, 0, mips_pkg::FN_SUBU), 25, 32'hffff_fffd, 1);
        // Memory, first load misses and holds the PC for the refill
        write_row(itype(mips_pkg::OP_ADDI, 0, 26, 'h40), 26, 32'h0000_0040, 1);
        silent_row(itype(mips_pkg::OP_SW, 26, 4, 0));
        write_row(itype(mips_pkg::OP_LW, 26, 27, 0), 27, 32'h1234_5678, 3);
        write_row(itype(mips_pkg::OP_LW, 26, 28, 0), 28, 32'h1234_5678, 1);
        // Write to r0 is dropped and r0 stays zero
        silent_row(itype(mips_pkg::OP_ADDI, 0, 0, 5));
        write_row(rtype(0, 1, 29, 0, mips_pkg::FN_ADD), 29, 32'h0000_0007, 1);
        silent_row(itype(mips_pkg::OP_SW, 26, 1, 0));
        write_row(itype(mips_pkg::OP_LW, 26, 30, 0), 30, 32'h0000_0007, 1);
        // Branches, each taken one skips a poison word
        silent_row(itype(mips_pkg::OP_BEQ, 1, 29, 1));
        silent_row(poison);
        silent_row(itype(mips_pkg::OP_BEQ, 1, 2, 1));
        write_row(itype(mips_pkg::OP_ADDI, 0, 24, 1), 24, 32'h0000_0001, 1);
        silent_row(itype(mips_pkg::OP_BNE, 1, 2, 1));
        silent_row(poison);
        silent_row(itype(mips_pkg::OP_BNE, 1, 29, 1));
        write_row(itype(mips_pkg::OP_ADDI, 0, 24, 2), 24, 32'h0000_0002, 1);
        silent_row(itype(mips_pkg::OP_BLEZ, 2, 0, 1));
        silent_row(poison);
        silent_row(itype(mips_pkg::OP_BLEZ, 1, 0, 1));
        write_row(itype(mips_pkg::OP_ADDI, 0, 24, 3), 24, 32'h0000_0003, 1);
        silent_row(itype(mips_pkg::OP_BGTZ, 1, 0, 1));
        silent_row(poison);
        silent_row(itype(mips_pkg::OP_BGTZ, 0, 0, 1));
        write_row(itype(mips_pkg::OP_ADDI, 0, 24, 4), 24, 32'h0000_0004, 1);
        silent_row(itype(mips_pkg::OP_BGEZ, 0, 1, 1));
        silent_row(poison);
        silent_row(itype(mips_pkg::OP_BGEZ, 2, 1, 1));
        write_row(itype(mips_pkg::OP_ADDI, 0, 24, 5), 24, 32'h0000_0005, 1);
        // Jumps, the call returns to 228
        silent_row(jtype(mips_pkg::OP_J, 224));
        silent_row(poison);
        write_row(jtype(mips_pkg::OP_JAL, 240), 31, 32'h0000_00e4, 1);
        write_row(itype(mips_pkg::OP_ADDI, 0, 25, 7), 25, 32'h0000_0007, 1);
        halt_pc = 32'(4 * prog_len);
        silent_row(syscall_word);
        silent_row(poison);
        write_row(itype(mips_pkg::OP_ADDI, 0, 24, 6), 24, 32'h0000_0006, 1);
        silent_row(rtype(31, 0, 0, 0, mips_pkg::FN_JR));
    endtask

    // One rising edge, with PC hold tracking and the timeout
    task automatic tick();
        @(posedge clk);
        cycle++;
        if (pc == last_pc) begin
            hold++;
        end else begin
            hold = 1;
        end
        last_pc = pc;
        if (cycle > cycle_limit && !timed_out) begin
            $display("Timeout: the program did not finish within %0d cycles", cycle_limit);
            timed_out = 1'b1;
        end
    endtask

    task automatic check_writeback();
        int idx;
        idx = int'(pc[31:2]);
        checks++;
        wb_count++;
        if (idx >= prog_len || !exp_en[idx]) begin
            errors++;
            $display("Error at %0t: unexpected write-back at pc %h, r%0d = %h",
                     $time, pc, wb_reg, wb_data);
        end else begin
            if (seen[idx]) begin
                errors++;
                $display("Error at %0t: repeated write-back at pc %h", $time, pc);
            end
            seen[idx] = 1'b1;
            if (wb_reg != exp_reg[idx]) begin
                errors++;
                $display("Error at %0t: pc %h writes r%0d, expected r%0d",
                         $time, pc, wb_reg, exp_reg[idx]);
            end
            if (wb_data != exp_val[idx]) begin
                errors++;
                $display("Error at %0t: pc %h writes %h, expected %h",
                         $time, pc, wb_data, exp_val[idx]);
            end
            if (hold != exp_hold[idx]) begin
                errors++;
                $display("Error at %0t: pc %h retired after %0d cycles, expected %0d",
                         $time, pc, hold, exp_hold[idx]);
            end
        end
    endtask

    initial begin
        clk       = 1'b0;
        arst_n    = 1'b0;
        instr     = '0;
        errors    = 0;
        checks    = 0;
        wb_count  = 0;
        cycle     = 0;
        hold      = 0;
        last_pc   = '1;
        timed_out = 1'b0;
        build_program();
        cycle_limit = 4 * prog_len + 20;

        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        while (wb_count < num_expected && !timed_out) begin
            tick();
            if (wb_en) begin
                check_writeback();
            end
        end

        while (!halted && !timed_out) begin
            tick();
            if (wb_en) begin
                check_writeback();
            end
        end

        if (!timed_out) begin
            checks++;
            if (pc != halt_pc) begin
                errors++;
                $display("Error at %0t: halted at pc %h, expected %h", $time, pc, halt_pc);
            end
            repeat (HALT_CYCLES) begin
                tick();
                checks++;
                if (pc != halt_pc || !halted) begin
                    errors++;
                    $display("Error at %0t: pc %h moved or halt dropped while halted",
                             $time, pc);
                end
                if (wb_en) begin
                    errors++;
                    $display("Error at %0t: write-back r%0d while halted", $time, wb_reg);
                end
            end
        end

        for (i = 0; i < prog_len; i++) begin
            if (exp_en[i] && !seen[i]) begin
                errors++;
                $display("Missing write-back: the instruction at pc %h never wrote", 4 * i);
            end
        end

        $display("Checks: %0d, write-backs: %0d of %0d, errors: %0d",
                 checks, wb_count, num_expected, errors);
        if (errors == 0 && !timed_out) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* mips_core.sv */
`timescale 1ns/100ps

module mips_core (
    input  logic               clk,
    input  logic               arst_n,
    input  mips_pkg::word_t    instr,
    output mips_pkg::word_t    pc,
    output logic               halted,
    output logic               wb_en,
    output mips_pkg::reg_idx_t wb_reg,
    output mips_pkg::word_t    wb_data
);
    ctrl_if cif ();
    dmem_if dbus ();

    control_unit u_control_unit (
        .clk    (clk),
        .arst_n (arst_n),
        .opcode (instr[31:26]),
        .func   (instr[5:0]),
        .halted (halted),
        .cif    (cif.ctrl)
    );

    datapath u_datapath (
        .clk     (clk),
        .arst_n  (arst_n),
        .instr   (instr),
        .pc      (pc),
        .cif     (cif.dp),
        .bus     (dbus.cpu),
        .wb_en   (wb_en),
        .wb_reg  (wb_reg),
        .wb_data (wb_data)
    );

    data_cache u_data_cache (
        .clk    (clk),
        .arst_n (arst_n),
        .bus    (dbus.mem)
    );

endmodule

/* datapath.sv */
`timescale 1ns/100ps

module datapath (
    input  logic               clk,
    input  logic               arst_n,
    input  mips_pkg::word_t    instr,
    output mips_pkg::word_t    pc,
    ctrl_if.dp                 cif,
    dmem_if.cpu                bus,
    output logic               wb_en,
    output mips_pkg::reg_idx_t wb_reg,
    output mips_pkg::word_t    wb_data
);
    mips_pkg::word_t    pc_plus4;
    mips_pkg::word_t    imm_ext;
    mips_pkg::word_t    branch_target;
    mips_pkg::word_t    jump_target;
    mips_pkg::word_t    next_pc;
    mips_pkg::word_t    rd1;
    mips_pkg::word_t    rd2;
    mips_pkg::word_t    alu_b;
    mips_pkg::word_t    alu_result;
    mips_pkg::word_t    wd;
    mips_pkg::reg_idx_t wa;
    mips_pkg::shamt_t   shift_amt;
    logic               rf_we;

    assign pc_plus4      = pc + 32'd4;
    assign imm_ext       = cif.is_unsigned ? {16'd0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};
    assign branch_target = pc_plus4 + {imm_ext[29:0], 2'b00};
    assign jump_target   = {pc_plus4[31:28], instr[25:0], 2'b00};

    // JR first, then J/JAL, then a taken branch
    always_comb begin
        if (cif.jump_register) begin
            next_pc = rd1;
        end else if (cif.jump) begin
            next_pc = jump_target;
        end else if (cif.branch) begin
            next_pc = branch_target;
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else if (cif.pc_we) begin
            pc <= next_pc;
        end
    end

    assign alu_b     = cif.alu_src ? imm_ext : rd2;
    // Variable shifts take the amount from rs
    assign shift_amt = cif.does_shift_amount_need ? instr[10:6] : rd1[4:0];

    alu u_alu (
        .a        (rd1),
        .b        (alu_b),
        .shamt    (shift_amt),
        .op       (cif.alu_operation),
        .result   (alu_result),
        .zero     (cif.zero),
        .negative (cif.negative)
    );

    assign wa = cif.link ? mips_pkg::LINK_REG : (cif.reg_dest ? instr[15:11] : instr[20:16]);
    assign wd = cif.pc_or_mem ? pc_plus4 : (cif.mem_or_reg ? bus.rdata : alu_result);
    // A stalled load writes only once the cache hits
    assign rf_we = cif.reg_write_enable & cif.pc_we;

    reg_file u_reg_file (
        .clk    (clk),
        .arst_n (arst_n),
        .ra1    (instr[25:21]),
        .ra2    (instr[20:16]),
        .rd1    (rd1),
        .rd2    (rd2),
        .we     (rf_we),
        .wa     (wa),
        .wd     (wd)
    );

    assign bus.addr  = alu_result;
    assign bus.wdata = rd2;
    assign bus.read  = cif.mem_read;
    assign bus.write = cif.mem_write_en;
    assign cif.hit   = bus.hit;

    // r0 writes are dropped and not reported
    assign wb_en   = rf_we & (wa != '0);
    assign wb_reg  = wa;
    assign wb_data = wd;

endmodule

/* data_cache.sv */
`timescale 1ns/100ps

module data_cache (
    input  logic clk,
    input  logic arst_n,
    dmem_if.mem  bus
);
    mips_pkg::cache_tag_t   tag_arr  [mips_pkg::CACHE_LINES];
    mips_pkg::word_t        data_arr [mips_pkg::CACHE_LINES];
    mips_pkg::word_t        ram      [mips_pkg::MEM_WORDS];
    logic [mips_pkg::CACHE_LINES-1:0]  valid;
    logic [mips_pkg::REFILL_CNT_W-1:0] refill_cnt;
    mips_pkg::cache_state_t state;
    mips_pkg::cache_idx_t   idx;
    mips_pkg::cache_tag_t   tag;
    mips_pkg::mem_idx_t     ram_idx;
    logic                   line_hit;
    logic                   fill;

    assign idx      = mips_pkg::cache_idx_t'(bus.addr[31:2]);
    assign tag      = mips_pkg::cache_tag_t'(bus.addr[31:2] >> mips_pkg::CACHE_IDX_W);
    assign ram_idx  = mips_pkg::mem_idx_t'(bus.addr[31:2]);
    assign line_hit = valid[idx] && (tag_arr[idx] == tag);
    assign fill     = (state == mips_pkg::CACHE_REFILL) &&
                      (refill_cnt == mips_pkg::REFILL_CNT_W'(mips_pkg::REFILL_CYCLES - 1));

    // Writes always finish in their cycle
    assign bus.hit   = bus.write || (bus.read && line_hit);
    assign bus.rdata = data_arr[idx];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= mips_pkg::CACHE_IDLE;
            refill_cnt <= '0;
            valid      <= '0;
        end else begin
            case (state)
                mips_pkg::CACHE_IDLE: begin
                    if (bus.read && !line_hit) begin
                        state      <= mips_pkg::CACHE_REFILL;
                        refill_cnt <= mips_pkg::REFILL_CNT_W'(1);
                    end
                end
                mips_pkg::CACHE_REFILL: begin
                    if (fill) begin
                        valid[idx] <= 1'b1;
                        state      <= mips_pkg::CACHE_DONE;
                    end else begin
                        refill_cnt <= refill_cnt + 1'b1;
                    end
                end
                default: state <= mips_pkg::CACHE_IDLE;
            endcase
        end
    end

    // Write-through, no allocate on a store miss
    always_ff @(posedge clk) begin
        if (fill) begin
            tag_arr[idx]  <= tag;
            data_arr[idx] <= ram[ram_idx];
        end
        if (bus.write) begin
            ram[ram_idx] <= bus.wdata;
            if (line_hit) begin
                data_arr[idx] <= bus.wdata;
            end
        end
    end

    a_rw_excl: assert property (@(posedge clk) disable iff (!arst_n)
        !(bus.read && bus.write));
    a_miss_latency: assert property (@(posedge clk) disable iff (!arst_n)
        (state == mips_pkg::CACHE_IDLE && bus.read && !line_hit)
        |-> ##(mips_pkg::REFILL_CYCLES) bus.hit);

endmodule

/* control_unit.sv */
`timescale 1ns/100ps

module control_unit (
    input  logic              clk,
    input  logic              arst_n,
    input  mips_pkg::opcode_t opcode,
    input  mips_pkg::funct_t  func,
    output logic              halted,
    ctrl_if.ctrl              cif
);
    logic is_syscall;
    logic is_mem_inst;
    logic should_branch;
    logic reg_write;
    logic mem_read;
    logic mem_write;

    alu_control u_alu_control (
        .opcode        (opcode),
        .func          (func),
        .alu_operation (cif.alu_operation)
    );

    always_comb begin
        cif.alu_src                = 1'b0;
        cif.reg_dest               = 1'b0;
        cif.pc_or_mem              = 1'b0;
        cif.mem_or_reg             = 1'b0;
        cif.jump                   = 1'b0;
        cif.jump_register          = 1'b0;
        cif.link                   = 1'b0;
        cif.does_shift_amount_need = 1'b0;
        cif.is_unsigned            = 1'b0;
        is_syscall                 = 1'b0;
        should_branch              = 1'b0;
        reg_write                  = 1'b0;
        mem_read                   = 1'b0;
        mem_write                  = 1'b0;
        case (opcode)
            mips_pkg::OP_RTYPE: begin
                case (func)
                    mips_pkg::FN_SYSCALL: is_syscall = 1'b1;
                    mips_pkg::FN_JR:      cif.jump_register = 1'b1;
                    mips_pkg::FN_SLL, mips_pkg::FN_SRL, mips_pkg::FN_SRA: begin
                        cif.reg_dest               = 1'b1;
                        cif.does_shift_amount_need = 1'b1;
                        reg_write                  = 1'b1;
                    end
                    mips_pkg::FN_ADD, mips_pkg::FN_ADDU, mips_pkg::FN_SUB, mips_pkg::FN_SUBU,
                    mips_pkg::FN_AND, mips_pkg::FN_OR, mips_pkg::FN_XOR, mips_pkg::FN_NOR,
                    mips_pkg::FN_SLT, mips_pkg::FN_SLLV, mips_pkg::FN_SRLV,
                    mips_pkg::FN_MULT, mips_pkg::FN_DIV: begin
                        cif.reg_dest = 1'b1;
                        reg_write    = 1'b1;
                    end
                    default: begin
                    end
                endcase
            end
            mips_pkg::OP_ADDI, mips_pkg::OP_SLTI, mips_pkg::OP_LUI: begin
                cif.alu_src = 1'b1;
                reg_write   = 1'b1;
            end
            // Zero-extended immediates
            mips_pkg::OP_ADDIU, mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_XORI: begin
                cif.alu_src     = 1'b1;
                cif.is_unsigned = 1'b1;
                reg_write       = 1'b1;
            end
            mips_pkg::OP_BEQ, mips_pkg::OP_BNE, mips_pkg::OP_BLEZ,
            mips_pkg::OP_BGTZ, mips_pkg::OP_BGEZ: should_branch = 1'b1;
            mips_pkg::OP_J: cif.jump = 1'b1;
            mips_pkg::OP_JAL: begin
                cif.jump      = 1'b1;
                cif.link      = 1'b1;
                cif.pc_or_mem = 1'b1;
                reg_write     = 1'b1;
            end
            mips_pkg::OP_LW: begin
                cif.alu_src    = 1'b1;
                cif.mem_or_reg = 1'b1;
                reg_write      = 1'b1;
                mem_read       = 1'b1;
            end
            mips_pkg::OP_SW: begin
                cif.alu_src = 1'b1;
                mem_write   = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // Branch taken from ALU flags
    always_comb begin
        cif.branch = 1'b0;
        if (should_branch) begin
            case (opcode)
                mips_pkg::OP_BEQ:  cif.branch = cif.zero;
                mips_pkg::OP_BNE:  cif.branch = ~cif.zero;
                mips_pkg::OP_BLEZ: cif.branch = cif.zero | cif.negative;
                mips_pkg::OP_BGTZ: cif.branch = ~cif.zero & ~cif.negative;
                mips_pkg::OP_BGEZ: cif.branch = ~cif.negative;
                default:           cif.branch = 1'b0;
            endcase
        end
    end

    assign is_mem_inst          = (opcode == mips_pkg::OP_LW) || (opcode == mips_pkg::OP_SW);
    assign cif.pc_we            = ~(halted | is_syscall) & (~is_mem_inst | cif.hit);
    assign cif.reg_write_enable = reg_write & ~halted;
    assign cif.mem_read         = mem_read & ~halted;
    assign cif.mem_write_en     = mem_write & ~halted;

    // Sticky halt
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            halted <= 1'b0;
        end else if (is_syscall) begin
            halted <= 1'b1;
        end
    end

    a_branch_jump_excl: assert property (@(posedge clk) disable iff (!arst_n)
        !(cif.branch && cif.jump));
    a_halt_holds_pc: assert property (@(posedge clk) disable iff (!arst_n)
        halted |-> !cif.pc_we);

endmodule

/* reg_file.sv */
`timescale 1ns/100ps

module reg_file (
    input  logic               clk,
    input  logic               arst_n,
    input  mips_pkg::reg_idx_t ra1,
    input  mips_pkg::reg_idx_t ra2,
    output mips_pkg::word_t    rd1,
    output mips_pkg::word_t    rd2,
    input  logic               we,
    input  mips_pkg::reg_idx_t wa,
    input  mips_pkg::word_t    wd
);
    mips_pkg::word_t regs [mips_pkg::NUM_REGS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < mips_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wa != '0)) begin
            regs[wa] <= wd;
        end
    end

    assign rd1 = regs[ra1];
    assign rd2 = regs[ra2];

    a_r0_zero: assert property (@(posedge clk) disable iff (!arst_n) regs[0] == '0);

endmodule

/* alu.sv */
`timescale 1ns/100ps

module alu (
    input  mips_pkg::word_t   a,
    input  mips_pkg::word_t   b,
    input  mips_pkg::shamt_t  shamt,
    input  mips_pkg::alu_op_t op,
    output mips_pkg::word_t   result,
    output logic              zero,
    output logic              negative
);

    always_comb begin
        case (op)
            mips_pkg::ALU_ADD:    result = a + b;
            mips_pkg::ALU_SUB:    result = a - b;
            mips_pkg::ALU_AND:    result = a & b;
            mips_pkg::ALU_OR:     result = a | b;
            mips_pkg::ALU_XOR:    result = a ^ b;
            mips_pkg::ALU_NOR:    result = ~(a | b);
            mips_pkg::ALU_SLT:    result = {31'd0, $signed(a) < $signed(b)};
            mips_pkg::ALU_SLL:    result = b << shamt;
            mips_pkg::ALU_SRL:    result = b >> shamt;
            mips_pkg::ALU_SRA:    result = $signed(b) >>> shamt;
            // Low word of the product
            mips_pkg::ALU_MUL:    result = a * b;
            mips_pkg::ALU_DIV: begin
                // Signed quotient, all ones on divide by zero
                if (b == '0) begin
                    result = '1;
                end else begin
                    result = $signed(a) / $signed(b);
                end
            end
            mips_pkg::ALU_LUI:    result = {b[15:0], 16'd0};
            mips_pkg::ALU_PASS_A: result = a;
            default:              result = a + b;
        endcase
    end

    assign zero     = (result == '0);
    assign negative = result[31];

endmodule

/* alu_control.sv */
`timescale 1ns/100ps

module alu_control (
    input  mips_pkg::opcode_t opcode,
    input  mips_pkg::funct_t  func,
    output mips_pkg::alu_op_t alu_operation
);

    always_comb begin
        alu_operation = mips_pkg::ALU_ADD;
        if (opcode == mips_pkg::OP_RTYPE) begin
            case (func)
                mips_pkg::FN_SUB, mips_pkg::FN_SUBU:  alu_operation = mips_pkg::ALU_SUB;
                mips_pkg::FN_AND:                     alu_operation = mips_pkg::ALU_AND;
                mips_pkg::FN_OR:                      alu_operation = mips_pkg::ALU_OR;
                mips_pkg::FN_XOR:                     alu_operation = mips_pkg::ALU_XOR;
                mips_pkg::FN_NOR:                     alu_operation = mips_pkg::ALU_NOR;
                mips_pkg::FN_SLT:                     alu_operation = mips_pkg::ALU_SLT;
                mips_pkg::FN_SLL, mips_pkg::FN_SLLV:  alu_operation = mips_pkg::ALU_SLL;
                mips_pkg::FN_SRL, mips_pkg::FN_SRLV:  alu_operation = mips_pkg::ALU_SRL;
                mips_pkg::FN_SRA:                     alu_operation = mips_pkg::ALU_SRA;
                mips_pkg::FN_MULT:                    alu_operation = mips_pkg::ALU_MUL;
                mips_pkg::FN_DIV:                     alu_operation = mips_pkg::ALU_DIV;
                mips_pkg::FN_JR:                      alu_operation = mips_pkg::ALU_PASS_A;
                default:                              alu_operation = mips_pkg::ALU_ADD;
            endcase
        end else begin
            case (opcode)
                mips_pkg::OP_SLTI:                    alu_operation = mips_pkg::ALU_SLT;
                mips_pkg::OP_ANDI:                    alu_operation = mips_pkg::ALU_AND;
                mips_pkg::OP_ORI:                     alu_operation = mips_pkg::ALU_OR;
                mips_pkg::OP_XORI:                    alu_operation = mips_pkg::ALU_XOR;
                mips_pkg::OP_LUI:                     alu_operation = mips_pkg::ALU_LUI;
                mips_pkg::OP_BEQ, mips_pkg::OP_BNE:   alu_operation = mips_pkg::ALU_SUB;
                // Flags then reflect rs alone
                mips_pkg::OP_BLEZ, mips_pkg::OP_BGTZ,
                mips_pkg::OP_BGEZ:                    alu_operation = mips_pkg::ALU_PASS_A;
                default:                              alu_operation = mips_pkg::ALU_ADD;
            endcase
        end
    end

endmodule

/* dmem_if.sv */
`timescale 1ns/100ps

interface dmem_if;
    mips_pkg::word_t addr;
    mips_pkg::word_t wdata;
    mips_pkg::word_t rdata;
    logic            read;
    logic            write;
    // Low during a read means data not ready yet
    logic            hit;

    modport cpu (output addr, wdata, read, write, input rdata, hit);
    modport mem (input addr, wdata, read, write, output rdata, hit);
endinterface

/* ctrl_if.sv */
`timescale 1ns/100ps

interface ctrl_if;
    logic alu_src;
    logic reg_dest;
    logic pc_or_mem;
    logic mem_or_reg;
    logic branch;
    logic jump;
    logic jump_register;
    logic link;
    logic reg_write_enable;
    logic does_shift_amount_need;
    logic is_unsigned;
    logic mem_read;
    logic mem_write_en;
    logic pc_we;
    mips_pkg::alu_op_t alu_operation;
    // Status back from the datapath
    logic zero;
    logic negative;
    logic hit;

    modport ctrl (
        output alu_src, reg_dest, pc_or_mem, mem_or_reg, branch, jump, jump_register, link,
               reg_write_enable, does_shift_amount_need, is_unsigned, mem_read, mem_write_en,
               pc_we, alu_operation,
        input  zero, negative, hit
    );

    modport dp (
        input  alu_src, reg_dest, pc_or_mem, mem_or_reg, branch, jump, jump_register, link,
               reg_write_enable, does_shift_amount_need, is_unsigned, mem_read, mem_write_en,
               pc_we, alu_operation,
        output zero, negative, hit
    );
endinterface

/* mips_pkg.sv */
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [4:0]  shamt_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_MUL, ALU_DIV, ALU_LUI, ALU_PASS_A
    } alu_op_t;

    typedef enum logic [1:0] {
        CACHE_IDLE, CACHE_REFILL, CACHE_DONE
    } cache_state_t;

    // Opcodes
    localparam opcode_t OP_RTYPE = 6'b000000;
    localparam opcode_t OP_BGEZ  = 6'b000001;
    localparam opcode_t OP_J     = 6'b000010;
    localparam opcode_t OP_JAL   = 6'b000011;
    localparam opcode_t OP_BEQ   = 6'b000100;
    localparam opcode_t OP_BNE   = 6'b000101;
    localparam opcode_t OP_BLEZ  = 6'b000110;
    localparam opcode_t OP_BGTZ  = 6'b000111;
    localparam opcode_t OP_ADDI  = 6'b001000;
    localparam opcode_t OP_ADDIU = 6'b001001;
    localparam opcode_t OP_SLTI  = 6'b001010;
    localparam opcode_t OP_ANDI  = 6'b001100;
    localparam opcode_t OP_ORI   = 6'b001101;
    localparam opcode_t OP_XORI  = 6'b001110;
    localparam opcode_t OP_LUI   = 6'b001111;
    localparam opcode_t OP_LW    = 6'b100011;
    localparam opcode_t OP_SW    = 6'b101011;

    // R-type function codes
    localparam funct_t FN_SLL     = 6'b000000;
    localparam funct_t FN_SRL     = 6'b000010;
    localparam funct_t FN_SRA     = 6'b000011;
    localparam funct_t FN_SLLV    = 6'b000100;
    localparam funct_t FN_SRLV    = 6'b000110;
    localparam funct_t FN_JR      = 6'b001000;
    localparam funct_t FN_SYSCALL = 6'b001100;
    localparam funct_t FN_MULT    = 6'b011000;
    localparam funct_t FN_DIV     = 6'b011010;
    localparam funct_t FN_ADD     = 6'b100000;
    localparam funct_t FN_ADDU    = 6'b100001;
    localparam funct_t FN_SUB     = 6'b100010;
    localparam funct_t FN_SUBU    = 6'b100011;
    localparam funct_t FN_AND     = 6'b100100;
    localparam funct_t FN_OR      = 6'b100101;
    localparam funct_t FN_XOR     = 6'b100110;
    localparam funct_t FN_NOR     = 6'b100111;
    localparam funct_t FN_SLT     = 6'b101010;

    localparam int NUM_REGS      = 32;
    localparam int CACHE_LINES   = 16;
    localparam int MEM_WORDS     = 256;
    localparam int REFILL_CYCLES = 2;
    localparam int REFILL_CNT_W  = $clog2(REFILL_CYCLES + 1);
    localparam int CACHE_IDX_W   = $clog2(CACHE_LINES);
    localparam int CACHE_TAG_W   = 30 - CACHE_IDX_W;
    localparam int MEM_IDX_W     = $clog2(MEM_WORDS);

    typedef logic [CACHE_IDX_W-1:0] cache_idx_t;
    typedef logic [CACHE_TAG_W-1:0] cache_tag_t;
    typedef logic [MEM_IDX_W-1:0]   mem_idx_t;

    localparam reg_idx_t LINK_REG = 5'd31;

endpackage
